//--- common/issue_params.svh
// Shared widths for the RV32I decode and issue stage
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// Datapath and register file
`define XLEN        32
`define REG_ADDR_W  5

// Instruction tracking and execution units
`define ID_W        3
`define NUM_UNITS   3

// Branch and jump offset, sign extended J-immediate width
`define PC_OFFSET_W 21

`endif

//--- common/issue_pkg.sv
// Types shared by the decoder, the issue stage and the operand former
`include "issue_params.svh"

package issue_pkg;

    // Trimmed opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011
    } opcode_t;

    // Bit positions in the unit masks
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_BR  = 2'd1,
        UNIT_LS  = 2'd2
    } unit_e;

    typedef enum logic [1:0] {
        ALU_CONSTANT = 2'd0,
        ALU_SLT      = 2'd1,
        ALU_SHIFT    = 2'd2,
        ALU_ADD_SUB  = 2'd3
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'd0,
        ALU_LOGIC_OR  = 2'd1,
        ALU_LOGIC_AND = 2'd2,
        ALU_LOGIC_ADD = 2'd3
    } alu_logic_op_t;

    typedef struct packed {
        logic                    valid;
        logic [`XLEN-1:0]        pc;
        logic [31:0]             instruction;
        logic [`ID_W-1:0]        id;
    } decode_packet_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0]  rs1_addr;
        logic [`REG_ADDR_W-1:0]  rs2_addr;
        logic                    uses_rs1;
        logic                    uses_rs2;
        logic [`REG_ADDR_W-1:0]  rd_addr;
        logic                    uses_rd;
        logic [`NUM_UNITS-1:0]   unit_needed;
        logic                    illegal;
        logic [2:0]              fn3;
        alu_op_t                 alu_op;
        alu_logic_op_t           alu_logic_op;
        logic                    alu_subtract;
        logic                    alu_imm_type;
        logic [`XLEN-1:0]        constant_alu;
        logic [`PC_OFFSET_W-1:0] pc_offset;
        logic                    is_call;
        logic                    is_return;
        logic                    is_jalr;
        logic                    br_use_signed;
        logic [11:0]             ls_offset;
        logic                    is_load;
        logic                    is_store;
        logic                    is_fence;
    } decoded_t;

    typedef struct packed {
        decoded_t                dec;
        logic [`XLEN-1:0]        pc;
        logic [31:0]             instruction;
        logic [`ID_W-1:0]        id;
    } issue_reg_t;

    typedef struct packed {
        logic [`XLEN-1:0]        rs1_data;
        logic [`XLEN-1:0]        rs2_data;
    } rf_read_t;

    typedef struct packed {
        logic [`XLEN:0]          in1;
        logic [`XLEN:0]          in2;
        logic [4:0]              shift_amount;
        logic [`XLEN-1:0]        shifter_in;
        logic                    arith;
        logic                    lshift;
        logic                    subtract;
        alu_logic_op_t           logic_op;
        alu_op_t                 alu_op;
        logic [`XLEN-1:0]        constant_adder;
    } alu_inputs_t;

    typedef struct packed {
        logic [`XLEN:0]          rs1;
        logic [`XLEN:0]          rs2;
        logic [`PC_OFFSET_W-1:0] pc_offset;
        logic                    jal;
        logic                    jalr;
        logic                    jal_jalr;
        logic                    is_call;
        logic                    is_return;
        logic [`XLEN-1:0]        issue_pc;
        logic [`XLEN-1:0]        pc_p4;
    } branch_inputs_t;

    typedef struct packed {
        logic [11:0]             offset;
        logic                    load;
        logic                    store;
        logic                    fence;
        logic [2:0]              fn3;
        logic [`XLEN-1:0]        rs1;
        logic [`XLEN-1:0]        rs2;
    } ls_inputs_t;

endpackage

//--- hdl/instruction_decoder.sv
// RV32I instruction decoder
// Purely combinational, one fetched instruction into a decoded_t
`timescale 1ns/1ps
`include "issue_params.svh"

module instruction_decoder (
    input  issue_pkg::decode_packet_t decode_i,
    output issue_pkg::decoded_t       decoded_o
);
    import issue_pkg::*;

    logic [31:0]            instr;
    opcode_t                opc;
    logic [2:0]             fn3;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rs1_link;
    logic                   rd_link;
    logic [19:0]            jal_imm;
    logic [11:0]            jalr_imm;
    logic [11:0]            br_imm;

    //////////////////////////////////////////////////
    // Field slicing
    assign instr = decode_i.instruction;
    assign opc   = opcode_t'(instr[6:2]);
    assign fn3   = instr[14:12];
    assign rs1   = instr[19:15];
    assign rd    = instr[11:7];

    assign decoded_o.rs1_addr = rs1;
    assign decoded_o.rs2_addr = instr[24:20];
    assign decoded_o.rd_addr  = rd;
    assign decoded_o.fn3      = fn3;

    // No forwarding path, so stores wait on rs2 like everything else
    assign decoded_o.uses_rs1 = opc inside {JALR_T, BRANCH_T, LOAD_T, STORE_T, ARITH_IMM_T, ARITH_T};
    assign decoded_o.uses_rs2 = opc inside {BRANCH_T, STORE_T, ARITH_T};
    assign decoded_o.uses_rd  = opc inside {LUI_T, AUIPC_T, JAL_T, JALR_T, LOAD_T,
                                            ARITH_IMM_T, ARITH_T};

    //////////////////////////////////////////////////
    // Unit selection
    assign decoded_o.unit_needed[UNIT_ALU] = opc inside {ARITH_T, ARITH_IMM_T, AUIPC_T, LUI_T};
    assign decoded_o.unit_needed[UNIT_BR]  = opc inside {BRANCH_T, JAL_T, JALR_T};
    assign decoded_o.unit_needed[UNIT_LS]  = opc inside {LOAD_T, STORE_T, FENCE_T};
    assign decoded_o.illegal               = ~|decoded_o.unit_needed;

    //////////////////////////////////////////////////
    // ALU controls
    always_comb begin
        if (opc inside {LUI_T, AUIPC_T, JAL_T, JALR_T}) begin
            decoded_o.alu_op = ALU_CONSTANT;
        end else begin
            case (fn3)
                3'b010, 3'b011: decoded_o.alu_op = ALU_SLT;
                3'b001, 3'b101: decoded_o.alu_op = ALU_SHIFT;
                default:        decoded_o.alu_op = ALU_ADD_SUB;
            endcase
        end
    end

    always_comb begin
        case (fn3)
            3'b100:  decoded_o.alu_logic_op = ALU_LOGIC_XOR;
            3'b110:  decoded_o.alu_logic_op = ALU_LOGIC_OR;
            3'b111:  decoded_o.alu_logic_op = ALU_LOGIC_AND;
            default: decoded_o.alu_logic_op = ALU_LOGIC_ADD;
        endcase
    end

    // SLT/SLTU compare by subtraction, SUB only in the register form
    assign decoded_o.alu_subtract = (fn3 inside {3'b010, 3'b011}) ||
                                    ((fn3 == 3'b000) && instr[30] && instr[5]);
    assign decoded_o.alu_imm_type = (opc == ARITH_IMM_T);

    // LUI, AUIPC results, and the link address for JAL/JALR/branches
    assign decoded_o.constant_alu = ((opc == LUI_T) ? '0 : decode_i.pc) +
        ((opc inside {LUI_T, AUIPC_T}) ? {instr[31:12], 12'b0} : `XLEN'(4));

    //////////////////////////////////////////////////
    // Branch controls
    assign rs1_link = rs1 inside {5'd1, 5'd5};
    assign rd_link  = rd inside {5'd1, 5'd5};

    assign decoded_o.is_call       = (opc inside {JAL_T, JALR_T}) && rd_link;
    assign decoded_o.is_return     = (opc == JALR_T) && rs1_link && (~rd_link || (rs1 != rd));
    assign decoded_o.is_jalr       = (opc == JALR_T);
    // BLTU and BGEU compare unsigned
    assign decoded_o.br_use_signed = !(fn3 inside {3'b110, 3'b111});

    assign jal_imm  = {instr[31], instr[19:12], instr[20], instr[30:21]};
    assign jalr_imm = instr[31:20];
    assign br_imm   = {instr[31], instr[7], instr[30:25], instr[11:8]};

    always_comb begin
        case (instr[3:2])
            2'b11:   decoded_o.pc_offset = `PC_OFFSET_W'(signed'({jal_imm, 1'b0}));
            2'b01:   decoded_o.pc_offset = `PC_OFFSET_W'(signed'(jalr_imm));
            default: decoded_o.pc_offset = `PC_OFFSET_W'(signed'({br_imm, 1'b0}));
        endcase
    end

    //////////////////////////////////////////////////
    // Load/store controls
    // S-type splits the offset around rd
    assign decoded_o.ls_offset = instr[5] ? {instr[31:25], instr[11:7]} : instr[31:20];
    assign decoded_o.is_load   = (opc == LOAD_T);
    assign decoded_o.is_store  = (opc == STORE_T);
    assign decoded_o.is_fence  = (opc == FENCE_T);

endmodule

//--- hdl/issue_stage.sv
// Issue stage, one-entry issue register with operand and unit checks
// Issues to ALU, branch or load/store, retires illegal opcodes
`timescale 1ns/1ps
`include "issue_params.svh"

module issue_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        decode_valid_i,
    input  issue_pkg::decoded_t         decoded_i,
    input  logic [`XLEN-1:0]            pc_i,
    input  logic [31:0]                 instruction_i,
    input  logic [`ID_W-1:0]            id_i,
    input  logic                        flush_i,
    input  logic                        issue_hold_i,
    input  logic [1:0]                  rs_inuse_i,
    input  logic [`NUM_UNITS-1:0]       unit_ready_i,
    output logic                        decode_advance_o,
    output issue_pkg::issue_reg_t       issue_o,
    output logic [1:0][`REG_ADDR_W-1:0] rf_addr_o,
    output logic [`NUM_UNITS-1:0]       issue_to_o,
    output logic                        instruction_issued_o,
    output logic                        illegal_o
);
    logic                  stage_valid;
    logic                  stage_ready;
    logic [1:0]            rs_conflict;
    logic                  operands_ready;
    logic                  issue_valid;
    logic [`NUM_UNITS-1:0] issue_ready;

    // Free when empty or when the occupant leaves this cycle
    assign stage_ready = (~stage_valid | (issue_valid & |issue_ready) | issue_o.dec.illegal)
                         & ~issue_hold_i;
    assign decode_advance_o = decode_valid_i & stage_ready;

    //////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk) begin
        if (stage_ready) begin
            issue_o.dec         <= decoded_i;
            issue_o.pc          <= pc_i;
            issue_o.instruction <= instruction_i;
            issue_o.id          <= id_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_valid <= 1'b0;
        end else if (stage_ready) begin
            stage_valid <= decode_valid_i;
        end
    end

    //////////////////////////////////////////////////
    // Issue determination
    assign rf_addr_o[0] = issue_o.dec.rs1_addr;
    assign rf_addr_o[1] = issue_o.dec.rs2_addr;

    // Only sources the instruction reads can stall it
    assign rs_conflict    = rs_inuse_i & {issue_o.dec.uses_rs2, issue_o.dec.uses_rs1};
    assign operands_ready = ~|rs_conflict;

    assign issue_ready = issue_o.dec.unit_needed & unit_ready_i;
    assign issue_valid = stage_valid & operands_ready & ~issue_hold_i;

    assign issue_to_o           = {`NUM_UNITS{issue_valid & ~flush_i}} & issue_ready;
    assign instruction_issued_o = issue_valid & ~flush_i & |issue_ready;
    assign illegal_o = stage_valid & issue_o.dec.illegal & ~issue_hold_i & ~flush_i;

    //////////////////////////////////////////////////
    // Assertions
    // Decoder marks at most one unit per opcode
    a_issue_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(issue_to_o)
    );

    a_no_issue_on_flush: assert property (
        @(posedge clk) disable iff (rst)
        flush_i |-> !instruction_issued_o && !illegal_o ##1 !stage_valid
    );

    a_advance_needs_valid: assert property (
        @(posedge clk) disable iff (rst) decode_advance_o |-> decode_valid_i
    );

endmodule

//--- hdl/unit_operands.sv
// Operand former for the ALU, branch and load/store units
`timescale 1ns/1ps
`include "issue_params.svh"

module unit_operands (
    input  issue_pkg::issue_reg_t     issue_i,
    input  issue_pkg::rf_read_t       rf_data_i,
    output issue_pkg::alu_inputs_t    alu_inputs_o,
    output issue_pkg::branch_inputs_t branch_inputs_o,
    output issue_pkg::ls_inputs_t     ls_inputs_o
);
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_rs2;
    logic             alu_unsigned;
    logic             br_signed;

    assign rs1_data = rf_data_i.rs1_data;
    assign rs2_data = rf_data_i.rs2_data;

    //////////////////////////////////////////////////
    // ALU
    // fn3 bit 0 set on SLTU/SLTIU
    assign alu_unsigned = issue_i.dec.fn3[0];
    assign alu_rs2 = issue_i.dec.alu_imm_type ?
                     `XLEN'(signed'(issue_i.instruction[31:20])) : rs2_data;

    assign alu_inputs_o.in1 = {rs1_data[`XLEN-1] & ~alu_unsigned, rs1_data};
    assign alu_inputs_o.in2 = {alu_rs2[`XLEN-1] & ~alu_unsigned, alu_rs2};

    // Shift amount from shamt field or rs2 low bits
    assign alu_inputs_o.shift_amount = issue_i.dec.alu_imm_type ?
                                       issue_i.dec.rs2_addr : rs2_data[4:0];
    assign alu_inputs_o.shifter_in     = rs1_data;
    assign alu_inputs_o.arith          = rs1_data[`XLEN-1] & issue_i.instruction[30];
    assign alu_inputs_o.lshift         = ~issue_i.dec.fn3[2];
    assign alu_inputs_o.subtract       = issue_i.dec.alu_subtract;
    assign alu_inputs_o.logic_op       = issue_i.dec.alu_logic_op;
    assign alu_inputs_o.alu_op         = issue_i.dec.alu_op;
    assign alu_inputs_o.constant_adder = issue_i.dec.constant_alu;

    //////////////////////////////////////////////////
    // Branch
    assign br_signed = issue_i.dec.br_use_signed;

    assign branch_inputs_o.rs1       = {rs1_data[`XLEN-1] & br_signed, rs1_data};
    assign branch_inputs_o.rs2       = {rs2_data[`XLEN-1] & br_signed, rs2_data};
    assign branch_inputs_o.pc_offset = issue_i.dec.pc_offset;
    // Opcode bit 3 only on JAL, bit 2 on JAL and JALR
    assign branch_inputs_o.jal       = issue_i.instruction[3];
    assign branch_inputs_o.jalr      = issue_i.dec.is_jalr;
    assign branch_inputs_o.jal_jalr  = issue_i.instruction[2];
    assign branch_inputs_o.is_call   = issue_i.dec.is_call;
    assign branch_inputs_o.is_return = issue_i.dec.is_return;
    assign branch_inputs_o.issue_pc  = issue_i.pc;
    assign branch_inputs_o.pc_p4     = issue_i.dec.constant_alu;

    //////////////////////////////////////////////////
    // Load/store
    assign ls_inputs_o.offset = issue_i.dec.ls_offset;
    assign ls_inputs_o.load   = issue_i.dec.is_load;
    assign ls_inputs_o.store  = issue_i.dec.is_store;
    assign ls_inputs_o.fence  = issue_i.dec.is_fence;
    assign ls_inputs_o.fn3    = issue_i.dec.fn3;
    assign ls_inputs_o.rs1    = rs1_data;
    assign ls_inputs_o.rs2    = rs2_data;

endmodule

//--- hdl/decode_issue.sv
// Decode and issue stage of a small in-order RV32I core
// Decoder, issue register and operand former
`timescale 1ns/1ps
`include "issue_params.svh"

module decode_issue (
    input  logic                        clk,
    input  logic                        rst,
    // Fetch side
    input  issue_pkg::decode_packet_t   decode_i,
    output logic                        decode_advance_o,
    // Pipeline control
    input  logic                        flush_i,
    input  logic                        issue_hold_i,
    // Register file
    input  logic [1:0]                  rs_inuse_i,
    output logic [1:0][`REG_ADDR_W-1:0] rf_addr_o,
    input  issue_pkg::rf_read_t         rf_data_i,
    // Execution units
    input  logic [`NUM_UNITS-1:0]       unit_ready_i,
    output logic [`NUM_UNITS-1:0]       issue_to_o,
    output logic [`ID_W-1:0]            issue_id_o,
    output logic                        instruction_issued_o,
    output issue_pkg::alu_inputs_t      alu_inputs_o,
    output issue_pkg::branch_inputs_t   branch_inputs_o,
    output issue_pkg::ls_inputs_t       ls_inputs_o,
    output logic                        illegal_o
);
    import issue_pkg::*;

    decoded_t   decoded;
    issue_reg_t issue;

    instruction_decoder u_decoder (
        .decode_i  (decode_i),
        .decoded_o (decoded)
    );

    issue_stage u_issue (
        .clk                  (clk),
        .rst                  (rst),
        .decode_valid_i       (decode_i.valid),
        .decoded_i            (decoded),
        .pc_i                 (decode_i.pc),
        .instruction_i        (decode_i.instruction),
        .id_i                 (decode_i.id),
        .flush_i              (flush_i),
        .issue_hold_i         (issue_hold_i),
        .rs_inuse_i           (rs_inuse_i),
        .unit_ready_i         (unit_ready_i),
        .decode_advance_o     (decode_advance_o),
        .issue_o              (issue),
        .rf_addr_o            (rf_addr_o),
        .issue_to_o           (issue_to_o),
        .instruction_issued_o (instruction_issued_o),
        .illegal_o            (illegal_o)
    );

    unit_operands u_operands (
        .issue_i         (issue),
        .rf_data_i       (rf_data_i),
        .alu_inputs_o    (alu_inputs_o),
        .branch_inputs_o (branch_inputs_o),
        .ls_inputs_o     (ls_inputs_o)
    );

    assign issue_id_o = issue.id;

endmodule

//--- dv/decode_issue_model.svh
// Reference model of the decode and issue stage
// Keeps the pending queue and derives expected bundles from the RV32I encoding
`ifndef DECODE_ISSUE_MODEL_SVH
`define DECODE_ISSUE_MODEL_SVH

decode_packet_t pend_q[$];
int unit_errors   = 0;
int alu_errors    = 0;
int branch_errors = 0;
int ls_errors     = 0;
int flag_errors   = 0;
int addr_errors   = 0;

//////////////////////////////////////////////////
// Decoding rules
function automatic logic [`NUM_UNITS-1:0] unit_of(logic [31:0] ins);
    case (ins[6:2])
        ARITH_T, ARITH_IMM_T, LUI_T, AUIPC_T: return `NUM_UNITS'(1) << UNIT_ALU;
        BRANCH_T, JAL_T, JALR_T:              return `NUM_UNITS'(1) << UNIT_BR;
        LOAD_T, STORE_T, FENCE_T:             return `NUM_UNITS'(1) << UNIT_LS;
        default:                              return '0;
    endcase
endfunction

// Bit 1 is rs2, bit 0 is rs1
function automatic logic [1:0] sources_of(logic [31:0] ins);
    case (ins[6:2])
        ARITH_T, BRANCH_T, STORE_T:  return 2'b11;
        JALR_T, LOAD_T, ARITH_IMM_T: return 2'b01;
        default:                     return 2'b00;
    endcase
endfunction

function automatic alu_inputs_t alu_expect(decode_packet_t p, rf_read_t rf);
    alu_inputs_t      e;
    logic [31:0]      ins;
    logic [2:0]       f3;
    logic             imm_form;
    logic [`XLEN-1:0] op2;
    ins      = p.instruction;
    f3       = ins[14:12];
    imm_form = (ins[6:2] == ARITH_IMM_T);
    op2      = imm_form ? {{20{ins[31]}}, ins[31:20]} : rf.rs2_data;
    // Unsigned forms have fn3 bit 0 set
    e.in1 = {rf.rs1_data[`XLEN-1] & ~f3[0], rf.rs1_data};
    e.in2 = {op2[`XLEN-1] & ~f3[0], op2};
    e.shift_amount = imm_form ? ins[24:20] : rf.rs2_data[4:0];
    e.shifter_in   = rf.rs1_data;
    e.arith        = ins[30] & rf.rs1_data[`XLEN-1];
    e.lshift       = ~f3[2];
    // SUB needs the register form, opcode bit 5
    e.subtract = (f3 == 3'b010) || (f3 == 3'b011) || ((f3 == 3'b000) && ins[30] && ins[5]);
    case (f3)
        3'b100:  e.logic_op = ALU_LOGIC_XOR;
        3'b110:  e.logic_op = ALU_LOGIC_OR;
        3'b111:  e.logic_op = ALU_LOGIC_AND;
        default: e.logic_op = ALU_LOGIC_ADD;
    endcase
    if (ins[6:2] == LUI_T || ins[6:2] == AUIPC_T) begin
        e.alu_op = ALU_CONSTANT;
    end else if (f3 == 3'b010 || f3 == 3'b011) begin
        e.alu_op = ALU_SLT;
    end else if (f3 == 3'b001 || f3 == 3'b101) begin
        e.alu_op = ALU_SHIFT;
    end else begin
        e.alu_op = ALU_ADD_SUB;
    end
    case (ins[6:2])
        LUI_T:   e.constant_adder = {ins[31:12], 12'b0};
        AUIPC_T: e.constant_adder = p.pc + {ins[31:12], 12'b0};
        default: e.constant_adder = p.pc + 4;
    endcase
    return e;
endfunction

function automatic branch_inputs_t branch_expect(decode_packet_t p, rf_read_t rf);
    branch_inputs_t e;
    logic [31:0]    ins;
    logic           sgn;
    logic           rd_link;
    logic           rs1_link;
    ins      = p.instruction;
    sgn      = !(ins[14:12] == 3'b110 || ins[14:12] == 3'b111);
    rd_link  = (ins[11:7] == 5'd1) || (ins[11:7] == 5'd5);
    rs1_link = (ins[19:15] == 5'd1) || (ins[19:15] == 5'd5);
    e.rs1 = {rf.rs1_data[`XLEN-1] & sgn, rf.rs1_data};
    e.rs2 = {rf.rs2_data[`XLEN-1] & sgn, rf.rs2_data};
    case (ins[6:2])
        JAL_T:   e.pc_offset = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        JALR_T:  e.pc_offset = {{9{ins[31]}}, ins[31:20]};
        default: e.pc_offset = {{8{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    endcase
    e.jal      = (ins[6:2] == JAL_T);
    e.jalr     = (ins[6:2] == JALR_T);
    e.jal_jalr = e.jal || e.jalr;
    // Push on a link rd, pop on a link rs1 unless both name one register
    e.is_call   = e.jal_jalr && rd_link;
    e.is_return = e.jalr && rs1_link && !(rd_link && ins[19:15] == ins[11:7]);
    e.issue_pc  = p.pc;
    e.pc_p4     = p.pc + 4;
    return e;
endfunction

function automatic ls_inputs_t ls_expect(decode_packet_t p, rf_read_t rf);
    ls_inputs_t  e;
    logic [31:0] ins;
    ins      = p.instruction;
    e.offset = (ins[6:2] == STORE_T) ? {ins[31:25], ins[11:7]} : ins[31:20];
    e.load   = (ins[6:2] == LOAD_T);
    e.store  = (ins[6:2] == STORE_T);
    e.fence  = (ins[6:2] == FENCE_T);
    e.fn3    = ins[14:12];
    e.rs1    = rf.rs1_data;
    e.rs2    = rf.rs2_data;
    return e;
endfunction

//////////////////////////////////////////////////
// Compare tasks
task automatic check_unit(string name, logic [`NUM_UNITS-1:0] exp, logic [`NUM_UNITS-1:0] act);
    if (exp !== act) begin
        $display("FAIL %s expected %b actual %b", name, exp, act);
        unit_errors++;
    end
endtask

task automatic check_alu(string name, alu_inputs_t exp, alu_inputs_t act);
    if (exp !== act) begin
        $display("FAIL %s expected %h actual %h", name, exp, act);
        alu_errors++;
    end
endtask

task automatic check_branch(string name, branch_inputs_t exp, branch_inputs_t act);
    if (exp !== act) begin
        $display("FAIL %s expected %h actual %h", name, exp, act);
        branch_errors++;
    end
endtask

task automatic check_ls(string name, ls_inputs_t exp, ls_inputs_t act);
    if (exp !== act) begin
        $display("FAIL %s expected %h actual %h", name, exp, act);
        ls_errors++;
    end
endtask

task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
        $display("FAIL %s expected %b actual %b", name, exp, act);
        flag_errors++;
    end
endtask

task automatic check_id(string name, logic [`ID_W-1:0] exp, logic [`ID_W-1:0] act);
    if (exp !== act) begin
        $display("FAIL %s expected %0d actual %0d", name, exp, act);
        flag_errors++;
    end
endtask

// Index 0 is rs1, index 1 is rs2
task automatic check_rf_addr(string name, logic [1:0][`REG_ADDR_W-1:0] exp,
                             logic [1:0][`REG_ADDR_W-1:0] act);
    if (exp !== act) begin
        $display("FAIL %s expected rs1 %0d rs2 %0d actual rs1 %0d rs2 %0d",
                 name, exp[0], exp[1], act[0], act[1]);
        addr_errors++;
    end
endtask

`endif

//--- dv/decode_issue_tb.sv
// Testbench for the decode and issue stage
// Random instruction stream and unit readiness checked against a model
`timescale 1ns/1ps
`include "issue_params.svh"

module decode_issue_tb;
    import issue_pkg::*;

    localparam int NUM_INSTR  = 400;
    localparam int CLK_PERIOD = 20;

    logic                        clk;
    logic                        rst;
    decode_packet_t              decode;
    logic                        decode_advance;
    logic                        flush;
    logic                        issue_hold;
    logic [1:0]                  rs_inuse;
    logic [1:0][`REG_ADDR_W-1:0] rf_addr;
    rf_read_t                    rf_data;
    logic [`NUM_UNITS-1:0]       unit_ready;
    logic [`NUM_UNITS-1:0]       issue_to;
    logic [`ID_W-1:0]            issue_id;
    logic                        instruction_issued;
    alu_inputs_t                 alu_inputs;
    branch_inputs_t              branch_inputs;
    ls_inputs_t                  ls_inputs;
    logic                        illegal;
    int                          accepted;
    logic                        keep_packet;

    `include "decode_issue_model.svh"

    decode_issue u_dut (
        .clk                  (clk),
        .rst                  (rst),
        .decode_i             (decode),
        .decode_advance_o     (decode_advance),
        .flush_i              (flush),
        .issue_hold_i         (issue_hold),
        .rs_inuse_i           (rs_inuse),
        .rf_addr_o            (rf_addr),
        .rf_data_i            (rf_data),
        .unit_ready_i         (unit_ready),
        .issue_to_o           (issue_to),
        .issue_id_o           (issue_id),
        .instruction_issued_o (instruction_issued),
        .alu_inputs_o         (alu_inputs),
        .branch_inputs_o      (branch_inputs),
        .ls_inputs_o          (ls_inputs),
        .illegal_o            (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Stimulus
    // Link registers x1 and x5 half of the time
    function automatic logic [4:0] link_pick();
        case ($urandom % 4)
            0:       return 5'd1;
            1:       return 5'd5;
            default: return 5'($urandom);
        endcase
    endfunction

    function automatic logic [31:0] random_instruction();
        logic [31:0] ins;
        ins = $urandom;
        case ($urandom % 11)
            0: ins[6:2] = LUI_T;
            1: ins[6:2] = AUIPC_T;
            2: begin
                ins[6:2]  = JAL_T;
                ins[11:7] = link_pick();
            end
            3: begin
                ins[6:2]   = JALR_T;
                ins[14:12] = 3'b000;
                ins[11:7]  = link_pick();
                ins[19:15] = link_pick();
            end
            4: begin
                ins[6:2] = BRANCH_T;
                // fn3 010 and 011 are reserved
                if (ins[14:13] == 2'b01) ins[14] = 1'b1;
            end
            5: begin
                ins[6:2] = LOAD_T;
                ins[13]  = ins[13] & ~ins[14] & ~ins[12];
            end
            6: begin
                ins[6:2] = STORE_T;
                ins[14]  = 1'b0;
                ins[13]  = ins[13] & ~ins[12];
            end
            7: begin
                ins[6:2]   = FENCE_T;
                ins[14:12] = 3'b000;
            end
            8: begin
                ins[6:2] = ARITH_IMM_T;
                // Shifts carry a shamt and a clean funct7
                if (ins[13:12] == 2'b01) begin
                    ins[31]    = 1'b0;
                    ins[29:25] = 5'b0;
                    if (!ins[14]) ins[30] = 1'b0;
                end
            end
            9: begin
                ins[6:2]   = ARITH_T;
                ins[31]    = 1'b0;
                ins[29:25] = 5'b0;
                if (!(ins[14:12] == 3'b000 || ins[14:12] == 3'b101)) ins[30] = 1'b0;
            end
            default: begin
                // SYSTEM, AMO, OP-FP and OP-IMM-32 are outside this core
                case ($urandom % 4)
                    0:       ins[6:2] = 5'b11100;
                    1:       ins[6:2] = 5'b01011;
                    2:       ins[6:2] = 5'b10100;
                    default: ins[6:2] = 5'b00110;
                endcase
            end
        endcase
        ins[1:0] = 2'b11;
        return ins;
    endfunction

    task automatic drive_cycle();
        if (!keep_packet) begin
            decode.valid       = ($urandom % 4) != 0;
            decode.pc          = $urandom & ~32'h3;
            decode.instruction = random_instruction();
            decode.id          = decode.id + 1'b1;
        end
        rs_inuse   = {($urandom % 4) == 0, ($urandom % 4) == 0};
        unit_ready = {($urandom % 4) != 0, ($urandom % 4) != 0, ($urandom % 4) != 0};
        issue_hold = ($urandom % 16) == 0;
        flush      = ($urandom % 32) == 0;
        rf_data    = {$urandom, $urandom};
    endtask

    //////////////////////////////////////////////////
    // Monitor sampling at the falling edge
    always @(negedge clk) begin
        decode_packet_t        head;
        logic [`NUM_UNITS-1:0] exp_unit;
        logic                  exp_illegal;
        logic                  leaving;
        string                 tag;
        if (!rst) begin
            exp_unit    = '0;
            exp_illegal = 1'b0;
            leaving     = (pend_q.size() == 0);
            tag         = "idle stage";
            if (pend_q.size() > 0) begin
                head = pend_q[0];
                tag  = $sformatf("id %0d instr %h", head.id, head.instruction);
                // Register file addresses come from the staged instruction
                check_rf_addr({tag, " rf_addr"},
                              {head.instruction[24:20], head.instruction[19:15]}, rf_addr);
                if (!issue_hold) begin
                    if (unit_of(head.instruction) == '0) begin
                        exp_illegal = !flush;
                        leaving     = 1'b1;
                    end else if ((rs_inuse & sources_of(head.instruction)) == 2'b00 &&
                                 (unit_of(head.instruction) & unit_ready) != '0) begin
                        exp_unit = flush ? '0 : unit_of(head.instruction);
                        leaving  = 1'b1;
                    end
                end
            end
            check_unit({tag, " issue_to"}, exp_unit, issue_to);
            check_flag({tag, " instruction_issued"}, |exp_unit, instruction_issued);
            check_flag({tag, " illegal"}, exp_illegal, illegal);
            check_flag({tag, " decode_advance"}, decode.valid && !issue_hold && leaving,
                       decode_advance);
            if (exp_unit != '0) begin
                check_id({tag, " issue_id"}, head.id, issue_id);
                if (exp_unit[UNIT_ALU]) begin
                    check_alu({tag, " alu"}, alu_expect(head, rf_data), alu_inputs);
                end
                if (exp_unit[UNIT_BR]) begin
                    check_branch({tag, " branch"}, branch_expect(head, rf_data), branch_inputs);
                end
                if (exp_unit[UNIT_LS]) begin
                    check_ls({tag, " ls"}, ls_expect(head, rf_data), ls_inputs);
                end
            end
            // Flush drops the staged entry and anything accepted with it
            if (flush) begin
                pend_q.delete();
            end else begin
                if (exp_unit != '0 || exp_illegal) void'(pend_q.pop_front());
                if (decode_advance) pend_q.push_back(decode);
            end
            if (decode_advance) accepted++;
            keep_packet = decode.valid && !decode_advance;
        end
    end

    //////////////////////////////////////////////////
    // Run control
    initial begin
        #(NUM_INSTR * 20 * CLK_PERIOD);
        $display("Watchdog expired, %0d of %0d instructions accepted", accepted, NUM_INSTR);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int total;
        void'($urandom(32'h9a8));
        clk         = 1'b0;
        rst         = 1'b1;
        decode      = '0;
        flush       = 1'b0;
        issue_hold  = 1'b0;
        rs_inuse    = 2'b00;
        unit_ready  = '0;
        rf_data     = '0;
        accepted    = 0;
        keep_packet = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        while (accepted < NUM_INSTR) begin
            drive_cycle();
            @(posedge clk);
            #1;
        end
        // Drain with every unit ready and no conflicts
        decode     = '0;
        rs_inuse   = 2'b00;
        unit_ready = '1;
        issue_hold = 1'b0;
        flush      = 1'b0;
        while (pend_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        total = unit_errors + alu_errors + branch_errors + ls_errors + flag_errors +
                addr_errors;
        $display("Errors: unit %0d, alu %0d, branch %0d, ls %0d, flag %0d, rf_addr %0d",
                 unit_errors, alu_errors, branch_errors, ls_errors, flag_errors,
                 addr_errors);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+common
+incdir+dv
common/issue_pkg.sv
hdl/instruction_decoder.sv
hdl/issue_stage.sv
hdl/unit_operands.sv
hdl/decode_issue.sv
dv/decode_issue_tb.sv

//--- Bender.yml
package:
  name: decode_issue

sources:
  - include_dirs:
      - common
    files:
      - common/issue_pkg.sv
      - hdl/instruction_decoder.sv
      - hdl/issue_stage.sv
      - hdl/unit_operands.sv
      - hdl/decode_issue.sv
  - target: test
    include_dirs:
      - common
      - dv
    files:
      - dv/decode_issue_tb.sv
